//--- pacman_render.f
+incdir+logic
+incdir+testbench
logic/render_pkg.sv
logic/frame_sequencer.sv
logic/cell_renderer.sv
logic/sprite_renderer.sv
logic/frame_buffer.sv
logic/vga_scanout.sv
logic/pacman_render_top.sv
testbench/tb_pacman_render.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_pacman_render
FILELIST   := pacman_render.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_render_model.svh
`ifndef TB_RENDER_MODEL_SVH
`define TB_RENDER_MODEL_SVH

logic [31:0]  lfsr_state;
logic         wall_map [0:511];   // Indexed by maze address
logic         food_map [0:511];
color_t       exp_canvas [0:`CANVAS_W*`CANVAS_H-1];
int           player_cx;          // Expected player cell
int           player_cy;

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
endfunction

// One LFSR step per bit taken, MSB first
task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
        value = (value << 1) | int'(lfsr_state[0]);
        lfsr_state = lfsr_step(lfsr_state);
    end
endtask

task automatic build_maps();
    int w;
    int f;
    for (int a = 0; a < 512; a++) begin
        wall_map[a] = 1'b0;
        food_map[a] = 1'b0;
    end
    for (int a = 0; a < `MAZE_W * `MAZE_H; a++) begin
        draw_bits(2, w);
        draw_bits(1, f);
        wall_map[a] = (w == 0);  // About one cell in four
        food_map[a] = (f == 1);  // Also under walls, where the wall must win
    end
endtask

// Saturating step inside the 29x13 maze
task automatic apply_move(input logic req, input int dir);
    if (!req)
        return;
    case (dir)
        0: if (player_cy > 0) player_cy--;
        1: if (player_cx > 0) player_cx--;
        2: if (player_cy < `MAZE_H - 1) player_cy++;
        default: if (player_cx < `MAZE_W - 1) player_cx++;
    endcase
endtask

task automatic build_canvas();
    int cx, cy, ox, oy, a;
    logic [24:0] mask;
    color_t c;
    mask = `PLAYER_MASK;
    for (int y = 0; y < `CANVAS_H; y++) begin
        for (int x = 0; x < `CANVAS_W; x++) begin
            cx = x / `CELL_PX;
            cy = y / `CELL_PX;
            ox = x % `CELL_PX;
            oy = y % `CELL_PX;
            c  = `BLANK_COLOR;  // Outside the maze stays black
            if (cx < `MAZE_W && cy < `MAZE_H) begin
                a = cy * `MAZE_W + cx;
                if (wall_map[a])
                    c = `WALL_COLOR;
                else if (food_map[a] && ox == `FOOD_OFFSET && oy == `FOOD_OFFSET)
                    c = `FOOD_COLOR;  // Centre dot only
            end
            // Opaque sprite pixels over the player's cell
            if (cx == player_cx && cy == player_cy && mask[oy * `CELL_PX + ox])
                c = `PLAYER_COLOR;
            exp_canvas[y * `CANVAS_W + x] = c;
        end
    end
endtask

`endif

//--- testbench/tb_pacman_render.sv
`timescale 1ns/10ps
`default_nettype none

`include "render_consts.svh"

module tb_pacman_render;
    import render_pkg::*;

    localparam int NUM_FRAMES     = 8;
    localparam int FRAME_PIXELS   = `CANVAS_W * `CANVAS_H;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 38_500 + 12_000;  // About 320k

    logic        clock     = 1'b0;
    logic        resetn    = 1'b0;
    logic        move_req  = 1'b0;
    dir_t        move_dir  = '0;
    logic        maze_wall = 1'b0;
    logic        maze_food = 1'b0;
    maze_addr_t  maze_addr;
    canvas_x_t   vga_x;
    canvas_y_t   vga_y;
    color_t      vga_color;
    logic        vga_plot;
    logic        frame_done;

    int cycle_count      = 0;
    int frames_done      = 0;
    int pix_count        = 0;  // Pixels plotted in the current frame
    int reset_errors     = 0;
    int order_errors     = 0;
    int color_errors     = 0;
    int sprite_errors    = 0;  // Mismatches inside the player's cell
    int handshake_errors = 0;
    int total_errors;

    `include "tb_render_model.svh"

    pacman_render_top dut (
        .clock(clock), .resetn(resetn),
        .move_req(move_req), .move_dir(move_dir),
        .maze_wall(maze_wall), .maze_food(maze_food), .maze_addr(maze_addr),
        .vga_x(vga_x), .vga_y(vga_y), .vga_color(vga_color),
        .vga_plot(vga_plot), .frame_done(frame_done)
    );

    always #4 clock = ~clock;  // 8 ns period

    // Maze ROMs with data one cycle after the address
    always @(posedge clock) begin
        maze_wall <= wall_map[maze_addr];
        maze_food <= food_map[maze_addr];
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d frames finished",
                     cycle_count, frames_done, NUM_FRAMES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Forced runs toward the edges then random moves
    task automatic choose_move(input int frame);
        int r;
        int d;
        draw_bits(2, r);
        draw_bits(2, d);
        case (frame)
            0, 1: d = 0;  // Up until row 0 saturates
            2, 3: d = 1;  // Left until column 0 saturates
            4: d = 2;
            5: d = 3;
            default: ;
        endcase
        move_req = (frame < 6) || (r != 0);
        move_dir = dir_t'(d);
        apply_move(move_req, d);
        build_canvas();
    endtask

    task automatic check_pixel();
        int ex;
        int ey;
        ex = pix_count % `CANVAS_W;  // Raster order with x fastest
        ey = pix_count / `CANVAS_W;
        assert (pix_count < FRAME_PIXELS) else begin
            handshake_errors++;
            $display("More than %0d pixels plotted in frame %0d", FRAME_PIXELS, frames_done);
        end
        if (pix_count < FRAME_PIXELS) begin
            assert (vga_x == canvas_x_t'(ex) && vga_y == canvas_y_t'(ey)) else begin
                order_errors++;
                $display("ERROR vga_x/vga_y got 0x%h/0x%h expected 0x%h/0x%h",
                         vga_x, vga_y, canvas_x_t'(ex), canvas_y_t'(ey));
            end
            assert (vga_color == exp_canvas[pix_count]) else begin
                if (ex / `CELL_PX == player_cx && ey / `CELL_PX == player_cy)
                    sprite_errors++;
                else
                    color_errors++;
                $display("ERROR vga_color at x=0x%h y=0x%h got 0x%h expected 0x%h",
                         canvas_x_t'(ex), canvas_y_t'(ey), vga_color, exp_canvas[pix_count]);
            end
        end
        pix_count++;
    endtask

    initial begin
        lfsr_state = 32'hf6ae_496b;
        player_cx  = `PLAYER_START_X;
        player_cy  = `PLAYER_START_Y;
        build_maps();
        choose_move(0);  // Sampled in the first S_MOVE after reset
        repeat (8) begin
            @(negedge clock);
            assert (vga_plot === 1'b0 && frame_done === 1'b0) else begin
                reset_errors++;
                $display("ERROR vga_plot/frame_done in reset got 0x%h/0x%h expected 0x0/0x0",
                         vga_plot, frame_done);
            end
        end
        resetn = 1'b1;
        while (frames_done < NUM_FRAMES) begin
            @(negedge clock);
            if (vga_plot)
                check_pixel();
            if (frame_done) begin
                // One pulse right after the last pixel
                assert (pix_count == FRAME_PIXELS && !vga_plot) else begin
                    handshake_errors++;
                    $display("frame_done pulsed after %0d pixels in frame %0d, not after %0d",
                             pix_count, frames_done, FRAME_PIXELS);
                end
                frames_done++;
                pix_count = 0;
                if (frames_done < NUM_FRAMES)
                    choose_move(frames_done);  // Next S_MOVE is two edges away
            end
        end
        total_errors = reset_errors + order_errors + color_errors + sprite_errors
                       + handshake_errors;
        $display("Errors: reset %0d, order %0d, color %0d, sprite %0d, handshake %0d, total %0d",
                 reset_errors, order_errors, color_errors, sprite_errors,
                 handshake_errors, total_errors);
        if (total_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/pacman_render_top.sv
`timescale 1ns/10ps
`default_nettype none

module pacman_render_top (
    input  wire                     clock,
    input  wire                     resetn,
    input  wire                     move_req,
    input  render_pkg::dir_t        move_dir,
    input  wire                     maze_wall,
    input  wire                     maze_food,
    output render_pkg::maze_addr_t  maze_addr,
    output render_pkg::canvas_x_t   vga_x,
    output render_pkg::canvas_y_t   vga_y,
    output render_pkg::color_t      vga_color,
    output logic                    vga_plot,
    output logic                    frame_done
);
    import render_pkg::*;

    logic       cells_start, sprite_start, scan_start;
    logic       cells_done, sprite_done, scan_done;
    cell_x_t    player_x;
    cell_y_t    player_y;
    logic       cell_wren, spr_wren;      // Cell walk and sprite writers
    pix_addr_t  cell_waddr, spr_waddr, raddr;
    color_t     cell_wdata, spr_wdata, rdata;

    frame_sequencer u_seq (
        .clock(clock), .resetn(resetn),
        .move_req(move_req), .move_dir(move_dir),
        .cells_done(cells_done), .sprite_done(sprite_done), .scan_done(scan_done),
        .cells_start(cells_start), .sprite_start(sprite_start), .scan_start(scan_start),
        .player_x(player_x), .player_y(player_y), .frame_done(frame_done)
    );

    cell_renderer u_cells (
        .clock(clock), .resetn(resetn), .start(cells_start),
        .maze_wall(maze_wall), .maze_food(maze_food), .maze_addr(maze_addr),
        .wren(cell_wren), .waddr(cell_waddr), .wdata(cell_wdata), .done(cells_done)
    );

    sprite_renderer u_sprite (
        .clock(clock), .resetn(resetn), .start(sprite_start),
        .player_x(player_x), .player_y(player_y),
        .wren(spr_wren), .waddr(spr_waddr), .wdata(spr_wdata), .done(sprite_done)
    );

    frame_buffer u_fb (
        .clock(clock),
        .a_wren(cell_wren), .a_waddr(cell_waddr), .a_wdata(cell_wdata),
        .b_wren(spr_wren), .b_waddr(spr_waddr), .b_wdata(spr_wdata),
        .raddr(raddr), .rdata(rdata)
    );

    vga_scanout u_scan (
        .clock(clock), .resetn(resetn), .start(scan_start), .rdata(rdata),
        .raddr(raddr), .vga_x(vga_x), .vga_y(vga_y), .vga_color(vga_color),
        .vga_plot(vga_plot), .done(scan_done)
    );

endmodule

`default_nettype wire

//--- logic/vga_scanout.sv
`timescale 1ns/10ps
`default_nettype none

`include "render_consts.svh"

module vga_scanout (
    input  wire                    clock,
    input  wire                    resetn,
    input  wire                    start,
    input  render_pkg::color_t     rdata,
    output render_pkg::pix_addr_t  raddr,
    output render_pkg::canvas_x_t  vga_x,
    output render_pkg::canvas_y_t  vga_y,
    output render_pkg::color_t     vga_color,
    output logic                   vga_plot,
    output logic                   done
);
    import render_pkg::*;

    canvas_x_t  x_cnt;
    canvas_y_t  y_cnt;
    logic       busy;
    logic       last_pix, last_q;

    assign last_pix = busy && (x_cnt == `CANVAS_W - 1) && (y_cnt == `CANVAS_H - 1);
    assign raddr    = to_pix_addr(x_cnt, y_cnt);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            busy     <= 1'b0;
            x_cnt    <= '0;
            y_cnt    <= '0;
            vga_plot <= 1'b0;
            last_q   <= 1'b0;
            done     <= 1'b0;
        end else begin
            if (start) begin
                busy  <= 1'b1;
                x_cnt <= '0;
                y_cnt <= '0;
            end else if (busy) begin
                if (x_cnt == `CANVAS_W - 1) begin
                    x_cnt <= '0;
                    if (y_cnt == `CANVAS_H - 1)
                        busy <= 1'b0;  // Raster complete
                    else
                        y_cnt <= y_cnt + 1'b1;
                end else
                    x_cnt <= x_cnt + 1'b1;
            end
            vga_plot <= busy;    // RAM data valid now
            last_q   <= last_pix;
            done     <= last_q;
        end
    end

    // Coordinates wait one cycle for the RAM
    always_ff @(posedge clock) begin
        vga_x <= x_cnt;
        vga_y <= y_cnt;
    end

    assign vga_color = rdata;

endmodule

`default_nettype wire

//--- logic/frame_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "render_consts.svh"

module frame_buffer (
    input  wire                    clock,
    input  wire                    a_wren,
    input  render_pkg::pix_addr_t  a_waddr,
    input  render_pkg::color_t     a_wdata,
    input  wire                    b_wren,
    input  render_pkg::pix_addr_t  b_waddr,
    input  render_pkg::color_t     b_wdata,
    input  render_pkg::pix_addr_t  raddr,
    output render_pkg::color_t     rdata
);
    import render_pkg::*;

    localparam int DEPTH = `CANVAS_W * `CANVAS_H;  // 19,200 words

    color_t     mem [0:DEPTH-1];
    logic       wr_en;
    pix_addr_t  wr_addr;
    color_t     wr_data;

    // Renderers never overlap, port a wins anyway
    assign wr_en   = a_wren | b_wren;
    assign wr_addr = a_wren ? a_waddr : b_waddr;
    assign wr_data = a_wren ? a_wdata : b_wdata;

    always_ff @(posedge clock) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rdata <= mem[raddr];  // Registered read
    end

endmodule

`default_nettype wire

//--- logic/sprite_renderer.sv
`timescale 1ns/10ps
`default_nettype none

`include "render_consts.svh"

module sprite_renderer (
    input  wire                    clock,
    input  wire                    resetn,
    input  wire                    start,
    input  render_pkg::cell_x_t    player_x,
    input  render_pkg::cell_y_t    player_y,
    output logic                   wren,
    output render_pkg::pix_addr_t  waddr,
    output render_pkg::color_t     wdata,
    output logic                   done
);
    import render_pkg::*;

    localparam logic [24:0] SPRITE_MASK = `PLAYER_MASK;

    offset_t     dx, dy;
    logic        busy;
    logic        last_off;
    logic [4:0]  mask_idx;  // dy*5+dx

    assign mask_idx = {2'b00, dy} * 5'(`CELL_PX) + {2'b00, dx};
    assign last_off = busy && (dx == `CELL_PX - 1) && (dy == `CELL_PX - 1);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            busy <= 1'b0;
            dx   <= '0;
            dy   <= '0;
            done <= 1'b0;
        end else begin
            if (start) begin
                busy <= 1'b1;
                dx   <= '0;
                dy   <= '0;
            end else if (busy) begin
                if (dx == `CELL_PX - 1) begin
                    dx <= '0;
                    if (dy == `CELL_PX - 1)
                        busy <= 1'b0;  // All 25 offsets visited
                    else
                        dy <= dy + 1'b1;
                end else
                    dx <= dx + 1'b1;
            end
            done <= last_off;  // 26 cycles after start
        end
    end

    // Transparent pixels leave the cell colour in place
    assign wren  = busy && SPRITE_MASK[mask_idx];
    assign waddr = to_pix_addr(to_canvas_x(player_x, dx), to_canvas_y(player_y, dy));
    assign wdata = `PLAYER_COLOR;

endmodule

`default_nettype wire

//--- logic/cell_renderer.sv
`timescale 1ns/10ps
`default_nettype none

`include "render_consts.svh"

module cell_renderer (
    input  wire                     clock,
    input  wire                     resetn,
    input  wire                     start,
    input  wire                     maze_wall,
    input  wire                     maze_food,
    output render_pkg::maze_addr_t  maze_addr,
    output logic                    wren,
    output render_pkg::pix_addr_t   waddr,
    output render_pkg::color_t      wdata,
    output logic                    done
);
    import render_pkg::*;

    cell_x_t    cell_x;
    cell_y_t    cell_y;
    offset_t    dx, dy;     // dx runs fastest
    logic       busy;
    logic       in_maze, food_spot, last_pix;
    logic       wr_valid, last_q;
    logic       in_maze_q, food_q;  // Aligned with ROM data
    pix_addr_t  addr_q;

    assign in_maze   = (cell_x < `MAZE_W) && (cell_y < `MAZE_H);
    assign food_spot = (dx == `FOOD_OFFSET) && (dy == `FOOD_OFFSET);
    assign last_pix  = busy && (dx == `CELL_PX - 1) && (dy == `CELL_PX - 1)
                       && (cell_x == `GRID_W - 1) && (cell_y == `GRID_H - 1);

    // Outside the maze the ROM is not looked at
    assign maze_addr = in_maze ? maze_addr_t'(cell_y) * maze_addr_t'(`MAZE_W)
                                 + maze_addr_t'(cell_x) : '0;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            busy     <= 1'b0;
            cell_x   <= '0;
            cell_y   <= '0;
            dx       <= '0;
            dy       <= '0;
            wr_valid <= 1'b0;
            last_q   <= 1'b0;
            done     <= 1'b0;
        end else begin
            if (start) begin
                busy   <= 1'b1;
                cell_x <= '0;
                cell_y <= '0;
                dx     <= '0;
                dy     <= '0;
            end else if (busy) begin
                if (dx == `CELL_PX - 1) begin
                    dx <= '0;
                    if (dy == `CELL_PX - 1) begin
                        dy <= '0;
                        if (cell_x == `GRID_W - 1) begin
                            cell_x <= '0;
                            if (cell_y == `GRID_H - 1) begin
                                cell_y <= '0;
                                busy   <= 1'b0;  // Whole canvas walked
                            end else
                                cell_y <= cell_y + 1'b1;
                        end else
                            cell_x <= cell_x + 1'b1;
                    end else
                        dy <= dy + 1'b1;
                end else
                    dx <= dx + 1'b1;
            end
            wr_valid <= busy;    // Write follows address by one
            last_q   <= last_pix;
            done     <= last_q;  // One past the last write
        end
    end

    always_ff @(posedge clock) begin
        addr_q    <= to_pix_addr(to_canvas_x(cell_x, dx), to_canvas_y(cell_y, dy));
        in_maze_q <= in_maze;
        food_q    <= food_spot;
    end

    assign wren  = wr_valid;
    assign waddr = addr_q;
    // Wall beats food, food only on the centre dot
    assign wdata = !in_maze_q ? `BLANK_COLOR :
                   maze_wall  ? `WALL_COLOR  :
                   (maze_food && food_q) ? `FOOD_COLOR : `BLANK_COLOR;

endmodule

`default_nettype wire

//--- logic/frame_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "render_consts.svh"

module frame_sequencer (
    input  wire                  clock,
    input  wire                  resetn,
    input  wire                  move_req,
    input  render_pkg::dir_t     move_dir,
    input  wire                  cells_done,
    input  wire                  sprite_done,
    input  wire                  scan_done,
    output logic                 cells_start,
    output logic                 sprite_start,
    output logic                 scan_start,
    output render_pkg::cell_x_t  player_x,
    output render_pkg::cell_y_t  player_y,
    output logic                 frame_done
);
    import render_pkg::*;

    seq_state_t state;

    assign frame_done = (state == S_SCAN) && scan_done;  // Frame ends with the last pixel

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state        <= S_MOVE;
            cells_start  <= 1'b0;
            sprite_start <= 1'b0;
            scan_start   <= 1'b0;
            player_x     <= cell_x_t'(`PLAYER_START_X);
            player_y     <= cell_y_t'(`PLAYER_START_Y);
        end else begin
            cells_start  <= 1'b0;  // Starts are single-cycle
            sprite_start <= 1'b0;
            scan_start   <= 1'b0;
            case (state)
                S_MOVE: begin
                    // One step per frame, clamped to the maze
                    if (move_req) begin
                        case (move_dir)
                            2'd0: if (player_y != '0) player_y <= player_y - 1'b1;  // Up
                            2'd1: if (player_x != '0) player_x <= player_x - 1'b1;  // Left
                            2'd2: if (player_y != cell_y_t'(`MAZE_H - 1))
                                player_y <= player_y + 1'b1;                          // Down
                            default: if (player_x != cell_x_t'(`MAZE_W - 1))
                                player_x <= player_x + 1'b1;                          // Right
                        endcase
                    end
                    cells_start <= 1'b1;
                    state       <= S_CELLS;
                end
                S_CELLS: if (cells_done) begin
                    sprite_start <= 1'b1;
                    state        <= S_SPRITE;
                end
                S_SPRITE: if (sprite_done) begin
                    scan_start <= 1'b1;
                    state      <= S_SCAN;
                end
                default: if (scan_done) state <= S_MOVE;  // Back for the next frame
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/render_pkg.sv
`default_nettype none

`include "render_consts.svh"

package render_pkg;

    typedef logic [11:0] color_t;      // 4:4:4 pixel
    typedef logic [14:0] pix_addr_t;   // y*160+x
    typedef logic [7:0]  canvas_x_t;
    typedef logic [6:0]  canvas_y_t;
    typedef logic [4:0]  cell_x_t;
    typedef logic [4:0]  cell_y_t;
    typedef logic [8:0]  maze_addr_t;  // cell_y*29+cell_x
    typedef logic [2:0]  offset_t;     // Pixel inside a cell
    typedef logic [1:0]  dir_t;        // 0 up, 1 left, 2 down, 3 right

    typedef enum logic [1:0] {
        S_MOVE,
        S_CELLS,
        S_SPRITE,
        S_SCAN
    } seq_state_t;

    // Cell column plus offset to pixel column
    function automatic canvas_x_t to_canvas_x(input cell_x_t cx, input offset_t off);
        return canvas_x_t'(cx) * canvas_x_t'(`CELL_PX) + canvas_x_t'(off);
    endfunction

    function automatic canvas_y_t to_canvas_y(input cell_y_t cy, input offset_t off);
        return canvas_y_t'(cy) * canvas_y_t'(`CELL_PX) + canvas_y_t'(off);
    endfunction

    // Linear frame buffer address
    function automatic pix_addr_t to_pix_addr(input canvas_x_t x, input canvas_y_t y);
        return pix_addr_t'(y) * pix_addr_t'(`CANVAS_W) + pix_addr_t'(x);
    endfunction

endpackage

`default_nettype wire

//--- logic/render_consts.svh
`ifndef RENDER_CONSTS_SVH
`define RENDER_CONSTS_SVH

// Canvas in pixels
`define CANVAS_W        160
`define CANVAS_H        120

// Cell edge, pixels
`define CELL_PX         5

// Canvas in cells
`define GRID_W          32
`define GRID_H          24

// Maze ROM extent, top-left of the grid
`define MAZE_W          29
`define MAZE_H          13

`define PLAYER_START_X  1   // Cell column after reset
`define PLAYER_START_Y  1   // Cell row after reset

`define WALL_COLOR      12'h0ff
`define FOOD_COLOR      12'hfff
`define BLANK_COLOR     12'h000
`define FOOD_OFFSET     2   // Dot at (2,2) inside the cell

// Bit dy*5+dx set = opaque, rows bottom to top
`define PLAYER_MASK     25'b01110_01111_00111_01111_01110
`define PLAYER_COLOR    12'hff0

`endif
